// ==== mips_isa_pkg.sv ====
`default_nettype none

package mips_isa_pkg;

	typedef logic [31:0] word_t;     // data word
	typedef logic [4:0]  reg_idx_t;  // register index

	// major opcodes, bits 31:26
	localparam logic [5:0] OP_RTYPE = 6'h00;
	localparam logic [5:0] OP_J     = 6'h02;
	localparam logic [5:0] OP_JAL   = 6'h03;
	localparam logic [5:0] OP_BEQ   = 6'h04;
	localparam logic [5:0] OP_BNE   = 6'h05;
	localparam logic [5:0] OP_ADDIU = 6'h09;
	localparam logic [5:0] OP_ORI   = 6'h0d;
	localparam logic [5:0] OP_LW    = 6'h23;
	localparam logic [5:0] OP_SW    = 6'h2b;

	// funct codes for r-type, bits 5:0
	localparam logic [5:0] FN_JR    = 6'h08;
	localparam logic [5:0] FN_ADDU  = 6'h21;
	localparam logic [5:0] FN_SUBU  = 6'h23;
	localparam logic [5:0] FN_AND   = 6'h24;
	localparam logic [5:0] FN_OR    = 6'h25;
	localparam logic [5:0] FN_SLT   = 6'h2a;

	// lsb positions of the instruction fields
	localparam int POS_OP = 26;
	localparam int POS_RS = 21;
	localparam int POS_RT = 16;
	localparam int POS_RD = 11;
	localparam int POS_FN = 0;

	localparam reg_idx_t REG_RA = 5'd31;  // jal link register

endpackage

`default_nettype wire

// ==== cpu_ctrl_pkg.sv ====
`default_nettype none

package cpu_ctrl_pkg;

	import mips_isa_pkg::*;

	typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT} alu_op_e;
	typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC4} wb_sel_e;
	typedef enum logic [2:0] {PC_SEQ, PC_BEQ, PC_BNE, PC_JMP, PC_REG} pc_sel_e;

	localparam int    IMEM_WORDS = 256;
	localparam int    DMEM_WORDS = 256;
	localparam int    IMEM_AW    = $clog2(IMEM_WORDS);  // word index bits
	localparam int    DMEM_AW    = $clog2(DMEM_WORDS);
	localparam string PROG_FILE  = "program.hex";

	// decode -> execute
	typedef struct packed {
		word_t       pc;
		word_t       rs_val;
		word_t       rt_val;
		logic [15:0] imm;
		logic [25:0] jfield;     // j/jal target field
		alu_op_e     alu_op;
		logic        sext;       // sign-extend imm, else zero
		logic        use_imm;    // operand b from imm
		wb_sel_e     wb_sel;
		pc_sel_e     pc_sel;
		logic        reg_write;
		reg_idx_t    waddr;
		logic        mem_write;
	} decoded_t;

	// execute -> result
	typedef struct packed {
		word_t    pc;
		word_t    alu_res;     // also the memory address
		word_t    store_data;
		wb_sel_e  wb_sel;
		logic     reg_write;
		reg_idx_t waddr;
		logic     mem_write;
		word_t    next_pc;     // resolved, goes back as redirect
	} executed_t;

endpackage

`default_nettype wire

// ==== stage_if.sv ====
`default_nettype none

// one-record handshake between pipeline stages
interface stage_if #(
	parameter type payload_t = logic
) ();

	logic     valid;  // sender has a record
	logic     ready;  // receiver can take it
	payload_t data;

	modport src (output valid, output data, input ready);
	modport dst (input valid, input data, output ready);

endinterface

`default_nettype wire

// ==== mips_regfile.sv ====
`default_nettype none

module mips_regfile import mips_isa_pkg::*; (
	input  logic     clk,
	input  logic     reset,
	input  reg_idx_t raddr_a,
	input  reg_idx_t raddr_b,
	output word_t    rdata_a,
	output word_t    rdata_b,
	input  logic     wen,
	input  reg_idx_t waddr,
	input  word_t    wdata
);

	word_t regs [32];

	assign rdata_a = regs[raddr_a];  // async read
	assign rdata_b = regs[raddr_b];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) regs[i] <= '0;
		end else if (wen && waddr != '0) begin  // $zero stays zero
			regs[waddr] <= wdata;
		end
	end

	// r0 must never take a value, whatever retires into it
	a_r0_zero: assert property (@(posedge clk) disable iff (reset) regs[0] == '0);

endmodule

`default_nettype wire

// ==== mips_decode.sv ====
`default_nettype none

module mips_decode import mips_isa_pkg::*, cpu_ctrl_pkg::*; (
	input  logic     clk,
	input  logic     reset,
	stage_if.src     dx,
	output reg_idx_t rf_raddr_a,
	output reg_idx_t rf_raddr_b,
	input  word_t    rf_rdata_a,
	input  word_t    rf_rdata_b,
	input  logic     redirect_valid,
	input  word_t    redirect_pc
);

	word_t    pc;
	logic     vld;                    // record on offer
	logic     busy;                   // issued, waiting for retire
	word_t    imem [IMEM_WORDS];
	word_t    instr;
	logic [5:0] opcode, funct;
	reg_idx_t rs, rt, rd;
	decoded_t dec;

	initial $readmemh(PROG_FILE, imem);

	assign instr  = imem[pc[IMEM_AW+1:2]];  // word index
	assign opcode = instr[POS_OP +: 6];
	assign funct  = instr[POS_FN +: 6];
	assign rs     = instr[POS_RS +: 5];
	assign rt     = instr[POS_RT +: 5];
	assign rd     = instr[POS_RD +: 5];

	assign rf_raddr_a = rs;
	assign rf_raddr_b = rt;

	// controller
	always_comb begin
		dec           = '0;                     // no-op unless matched
		dec.pc        = pc;
		dec.rs_val    = rf_rdata_a;
		dec.rt_val    = rf_rdata_b;
		dec.imm       = instr[15:0];
		dec.jfield    = instr[25:0];
		dec.alu_op    = ALU_ADD;
		dec.wb_sel    = WB_ALU;
		dec.pc_sel    = PC_SEQ;
		dec.waddr     = rt;                     // i-type default
		case (opcode)
			OP_RTYPE: begin
				dec.waddr     = rd;
				dec.reg_write = 1'b1;
				case (funct)
					FN_ADDU: dec.alu_op = ALU_ADD;
					FN_SUBU: dec.alu_op = ALU_SUB;
					FN_AND:  dec.alu_op = ALU_AND;
					FN_OR:   dec.alu_op = ALU_OR;
					FN_SLT:  dec.alu_op = ALU_SLT;
					FN_JR: begin
						dec.reg_write = 1'b0;
						dec.pc_sel    = PC_REG;
					end
					default: dec.reg_write = 1'b0;  // unknown funct, nop
				endcase
			end
			OP_ADDIU: {dec.sext, dec.use_imm, dec.reg_write} = 3'b111;
			OP_ORI: begin
				dec.alu_op = ALU_OR;
				{dec.use_imm, dec.reg_write} = 2'b11;  // zero-extended
			end
			OP_LW: begin
				{dec.sext, dec.use_imm, dec.reg_write} = 3'b111;
				dec.wb_sel = WB_MEM;
			end
			OP_SW: {dec.sext, dec.use_imm, dec.mem_write} = 3'b111;
			OP_BEQ: dec.pc_sel = PC_BEQ;
			OP_BNE: dec.pc_sel = PC_BNE;
			OP_J:   dec.pc_sel = PC_JMP;
			OP_JAL: begin
				dec.pc_sel    = PC_JMP;
				dec.wb_sel    = WB_PC4;
				dec.reg_write = 1'b1;
				dec.waddr     = REG_RA;
			end
			default: ;
		endcase
	end

	assign dx.valid = vld;
	assign dx.data  = dec;

	always_ff @(posedge clk) begin
		if (reset) begin
			pc   <= '0;
			vld  <= 1'b1;          // pc 0 goes out right after reset
			busy <= 1'b0;
		end else if (redirect_valid) begin
			pc   <= redirect_pc;
			vld  <= 1'b1;
			busy <= 1'b0;
		end else if (dx.valid && dx.ready) begin
			vld  <= 1'b0;          // idle till retire
			busy <= 1'b1;
		end
	end

	// single instruction in flight, a retire only answers an issued one
	a_no_issue_busy: assert property (@(posedge clk) disable iff (reset)
		redirect_valid |-> busy);

endmodule

`default_nettype wire

// ==== mips_execute.sv ====
`default_nettype none

module mips_execute import mips_isa_pkg::*, cpu_ctrl_pkg::*; (
	input  logic clk,
	input  logic reset,
	stage_if.dst dx,
	stage_if.src xr
);

	decoded_t  d;
	executed_t res;
	executed_t out_q;          // one-entry output register
	logic      full;
	word_t     imm_ext, op_b, alu_res;
	word_t     pc4, br_tgt, jmp_tgt, next_pc;

	assign d = dx.data;

	assign imm_ext = d.sext ? {{16{d.imm[15]}}, d.imm} : {16'b0, d.imm};
	assign op_b    = d.use_imm ? imm_ext : d.rt_val;

	always_comb begin
		case (d.alu_op)
			ALU_SUB: alu_res = d.rs_val - op_b;
			ALU_AND: alu_res = d.rs_val & op_b;
			ALU_OR:  alu_res = d.rs_val | op_b;
			ALU_SLT: alu_res = {31'b0, $signed(d.rs_val) < $signed(op_b)};
			default: alu_res = d.rs_val + op_b;
		endcase
	end

	assign pc4     = d.pc + 32'd4;
	assign br_tgt  = pc4 + {{14{d.imm[15]}}, d.imm, 2'b00};  // always signed offset
	assign jmp_tgt = {pc4[31:28], d.jfield, 2'b00};

	always_comb begin
		case (d.pc_sel)
			PC_BEQ:  next_pc = (d.rs_val == d.rt_val) ? br_tgt : pc4;
			PC_BNE:  next_pc = (d.rs_val != d.rt_val) ? br_tgt : pc4;
			PC_JMP:  next_pc = jmp_tgt;
			PC_REG:  next_pc = d.rs_val;  // jr
			default: next_pc = pc4;
		endcase
	end

	always_comb begin
		res            = '0;
		res.pc         = d.pc;
		res.alu_res    = alu_res;
		res.store_data = d.rt_val;      // sw data
		res.wb_sel     = d.wb_sel;
		res.reg_write  = d.reg_write;
		res.waddr      = d.waddr;
		res.mem_write  = d.mem_write;
		res.next_pc    = next_pc;
	end

	assign dx.ready = !full;            // only when empty
	assign xr.valid = full;
	assign xr.data  = out_q;

	always_ff @(posedge clk) begin
		if (reset)
			full <= 1'b0;
		else if (dx.valid && dx.ready)
			full <= 1'b1;
		else if (xr.valid && xr.ready)
			full <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (dx.valid && dx.ready) out_q <= res;
	end

endmodule

`default_nettype wire

// ==== mips_result.sv ====
`default_nettype none

module mips_result import mips_isa_pkg::*, cpu_ctrl_pkg::*; (
	input  logic     clk,
	input  logic     reset,
	stage_if.dst     xr,
	output logic     rf_wen,
	output reg_idx_t rf_waddr,
	output word_t    rf_wdata,
	output logic     redirect_valid,
	output word_t    redirect_pc,
	output logic     retire_valid,
	input  logic     retire_ready,
	output word_t    retire_pc,
	output logic     retire_wen,
	output reg_idx_t retire_waddr,
	output word_t    retire_wdata
);

	executed_t rec;                   // held record
	logic      full;
	logic      retire;                // retire handshake this cycle
	word_t     dmem [DMEM_WORDS];
	word_t     mem_rdata, wb_data;
	logic [DMEM_AW-1:0] widx;

	initial begin
		for (int i = 0; i < DMEM_WORDS; i++) dmem[i] = '0;  // untouched reads give 0
	end

	assign widx      = rec.alu_res[DMEM_AW+1:2];
	assign mem_rdata = dmem[widx];

	always_comb begin
		case (rec.wb_sel)
			WB_MEM:  wb_data = mem_rdata;
			WB_PC4:  wb_data = rec.pc + 32'd4;  // jal link
			default: wb_data = rec.alu_res;
		endcase
	end

	assign xr.ready     = !full;
	assign retire_valid = full;
	assign retire       = retire_valid && retire_ready;
	assign retire_pc    = rec.pc;
	assign retire_wen   = rec.reg_write;
	assign retire_waddr = rec.waddr;
	assign retire_wdata = wb_data;

	assign rf_wen   = retire && rec.reg_write;  // commit on handshake only
	assign rf_waddr = rec.waddr;
	assign rf_wdata = wb_data;

	always_ff @(posedge clk) begin
		if (reset) begin
			full           <= 1'b0;
			redirect_valid <= 1'b0;
		end else begin
			redirect_valid <= retire;         // one-cycle pulse
			if (xr.valid && xr.ready)
				full <= 1'b1;
			else if (retire)
				full <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (xr.valid && xr.ready) rec <= xr.data;
		if (retire) redirect_pc <= rec.next_pc;
		if (retire && rec.mem_write) dmem[widx] <= rec.store_data;  // sw
	end

	// stalled retire record must not move
	a_retire_hold: assert property (@(posedge clk) disable iff (reset)
		retire_valid && !retire_ready |=> retire_valid && $stable(retire_pc)
			&& $stable(retire_wen) && $stable(retire_waddr) && $stable(retire_wdata));

endmodule

`default_nettype wire

// ==== mips_cpu.sv ====
`default_nettype none

module mips_cpu import mips_isa_pkg::*, cpu_ctrl_pkg::*; (
	input  logic     clk,
	input  logic     reset,
	output logic     retire_valid,
	input  logic     retire_ready,
	output word_t    retire_pc,
	output logic     retire_wen,
	output reg_idx_t retire_waddr,
	output word_t    retire_wdata
);

	reg_idx_t rf_raddr_a, rf_raddr_b, rf_waddr;
	word_t    rf_rdata_a, rf_rdata_b, rf_wdata;
	logic     rf_wen;
	logic     redirect_valid;  // retire -> decode
	word_t    redirect_pc;

	stage_if #(.payload_t(decoded_t))  dx ();  // decode -> execute
	stage_if #(.payload_t(executed_t)) xr ();  // execute -> result

	mips_decode u_decode (
		.clk(clk), .reset(reset), .dx(dx),
		.rf_raddr_a(rf_raddr_a), .rf_raddr_b(rf_raddr_b),
		.rf_rdata_a(rf_rdata_a), .rf_rdata_b(rf_rdata_b),
		.redirect_valid(redirect_valid), .redirect_pc(redirect_pc)
	);

	mips_execute u_execute (.clk(clk), .reset(reset), .dx(dx), .xr(xr));

	mips_result u_result (
		.clk(clk), .reset(reset), .xr(xr),
		.rf_wen(rf_wen), .rf_waddr(rf_waddr), .rf_wdata(rf_wdata),
		.redirect_valid(redirect_valid), .redirect_pc(redirect_pc),
		.retire_valid(retire_valid), .retire_ready(retire_ready),
		.retire_pc(retire_pc), .retire_wen(retire_wen),
		.retire_waddr(retire_waddr), .retire_wdata(retire_wdata)
	);

	mips_regfile u_regfile (
		.clk(clk), .reset(reset),
		.raddr_a(rf_raddr_a), .raddr_b(rf_raddr_b),
		.rdata_a(rf_rdata_a), .rdata_b(rf_rdata_b),
		.wen(rf_wen), .waddr(rf_waddr), .wdata(rf_wdata)
	);

endmodule

`default_nettype wire

// ==== tb_retire_checker.sv ====
`default_nettype none

module tb_retire_checker import mips_isa_pkg::*, cpu_ctrl_pkg::*; (
	input  logic     clk,
	input  logic     reset,
	input  logic     retire_valid,
	input  logic     retire_ready,
	input  word_t    retire_pc,
	input  logic     retire_wen,
	input  reg_idx_t retire_waddr,
	input  word_t    retire_wdata,
	output int       errors,
	output int       retired
);

	// expected effect of one instruction
	typedef struct packed {
		word_t    pc;
		logic     wen;
		reg_idx_t waddr;
		word_t    wdata;
		word_t    next_pc;
		logic     mem_we;
		word_t    mem_addr;
		word_t    mem_data;
	} ref_rec_t;

	word_t    imem [IMEM_WORDS];  // model copies of the machine state
	word_t    regs [32];
	word_t    dmem [DMEM_WORDS];
	word_t    pc;
	ref_rec_t exp_rec;
	int       n;

	initial begin
		$readmemh(PROG_FILE, imem);
		for (int i = 0; i < 32; i++) regs[i] = '0;
		for (int i = 0; i < DMEM_WORDS; i++) dmem[i] = '0;
	end

	// instruction set model, one step
	function automatic ref_rec_t ref_step(word_t cur_pc);
		ref_rec_t   r;
		word_t      instr, a, b, sx, zx, pc4;
		logic [5:0] op, fn;
		instr = imem[cur_pc[IMEM_AW+1:2]];
		op    = instr[31:26];
		fn    = instr[5:0];
		a     = regs[instr[25:21]];
		b     = regs[instr[20:16]];
		sx    = {{16{instr[15]}}, instr[15:0]};
		zx    = {16'b0, instr[15:0]};
		pc4   = cur_pc + 32'd4;
		r         = '0;
		r.pc      = cur_pc;
		r.waddr   = instr[20:16];  // rt unless told otherwise
		r.next_pc = pc4;
		case (op)
			OP_RTYPE: begin
				r.wen   = 1'b1;
				r.waddr = instr[15:11];
				case (fn)
					FN_ADDU: r.wdata = a + b;
					FN_SUBU: r.wdata = a - b;
					FN_AND:  r.wdata = a & b;
					FN_OR:   r.wdata = a | b;
					FN_SLT:  r.wdata = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					FN_JR: begin
						r.wen     = 1'b0;
						r.next_pc = a;
					end
					default: r.wen = 1'b0;
				endcase
			end
			OP_ADDIU: {r.wen, r.wdata} = {1'b1, a + sx};
			OP_ORI:   {r.wen, r.wdata} = {1'b1, a | zx};  // zero-extended
			OP_LW:    {r.wen, r.wdata} = {1'b1, dmem[(a + sx) >> 2]};
			OP_SW: begin
				r.mem_we   = 1'b1;
				r.mem_addr = a + sx;
				r.mem_data = b;
			end
			OP_BEQ: if (a == b) r.next_pc = pc4 + (sx << 2);
			OP_BNE: if (a != b) r.next_pc = pc4 + (sx << 2);
			OP_J:   r.next_pc = {pc4[31:28], instr[25:0], 2'b00};
			OP_JAL: begin
				r.next_pc = {pc4[31:28], instr[25:0], 2'b00};
				r.wen     = 1'b1;
				r.waddr   = REG_RA;
				r.wdata   = pc4;          // link
			end
			default: ;                    // no-op
		endcase
		return r;
	endfunction

	// 1 on mismatch, with the error line
	function automatic int field_differs(string name, word_t exp_v, word_t act_v);
		if (exp_v !== act_v) begin
			$display("FAILED t=%0t pc=%h %s expected %h got %h", $time, pc, name, exp_v, act_v);
			return 1;
		end
		return 0;
	endfunction

	always @(posedge clk) begin
		if (reset) begin
			pc = '0;
		end else if (retire_valid && retire_ready) begin
			exp_rec = ref_step(pc);
			n = 0;
			n += field_differs("pc", exp_rec.pc, retire_pc);
			n += field_differs("wen", {31'b0, exp_rec.wen}, {31'b0, retire_wen});
			if (exp_rec.wen) begin  // addr and data only mean something on a write
				n += field_differs("waddr", {27'b0, exp_rec.waddr}, {27'b0, retire_waddr});
				n += field_differs("wdata", exp_rec.wdata, retire_wdata);
			end
			if (exp_rec.wen && exp_rec.waddr != '0) regs[exp_rec.waddr] = exp_rec.wdata;
			if (exp_rec.mem_we) dmem[exp_rec.mem_addr[DMEM_AW+1:2]] = exp_rec.mem_data;
			pc = exp_rec.next_pc;
			errors  <= errors + n;
			retired <= retired + 1;
		end
	end

endmodule

`default_nettype wire

// ==== tb_mips_cpu.sv ====
`default_nettype none

module tb_mips_cpu import mips_isa_pkg::*; ();

	logic     clk;
	logic     reset;
	logic     retire_valid;
	logic     retire_ready;
	word_t    retire_pc;
	logic     retire_wen;
	reg_idx_t retire_waddr;
	word_t    retire_wdata;
	int       errors;         // from the checker
	int       retired;
	int       waited;
	int       timeouts;
	integer   seed = 32'h4021;

	mips_cpu u_mips_cpu (
		.clk(clk), .reset(reset),
		.retire_valid(retire_valid), .retire_ready(retire_ready),
		.retire_pc(retire_pc), .retire_wen(retire_wen),
		.retire_waddr(retire_waddr), .retire_wdata(retire_wdata)
	);

	tb_retire_checker u_checker (
		.clk(clk), .reset(reset),
		.retire_valid(retire_valid), .retire_ready(retire_ready),
		.retire_pc(retire_pc), .retire_wen(retire_wen),
		.retire_waddr(retire_waddr), .retire_wdata(retire_wdata),
		.errors(errors), .retired(retired)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// retire back-pressure, low about 30% of cycles
	initial begin
		forever begin
			@(negedge clk);
			retire_ready = ({$random(seed)} % 10) >= 3;
		end
	end

	initial begin
		reset        = 1'b1;
		retire_ready = 1'b0;
		timeouts     = 0;
		waited       = 0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		while (retired < 60 && waited < 2000) begin  // 60 retires or give up
			@(posedge clk);
			waited++;
		end
		if (retired < 60) begin
			$display("timeout waiting for retire");
			timeouts = 1;
		end
		@(negedge clk);
		$display("errors %0d, timeouts %0d, retired %0d", errors, timeouts, retired);
		if (errors == 0 && timeouts == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== program.hex ====
// one 32-bit instruction word per line, stored from pc 0 upward
// the text after each word is its assembly form
2401fffb  // 0x00 addiu $1, $0, -5
34028001  // 0x04 ori   $2, $0, 0x8001
00221821  // 0x08 addu  $3, $1, $2
00412023  // 0x0c subu  $4, $2, $1
00222824  // 0x10 and   $5, $1, $2
00223025  // 0x14 or    $6, $1, $2
0022382a  // 0x18 slt   $7, $1, $2
ac020008  // 0x1c sw    $2, 8($0)
8c080008  // 0x20 lw    $8, 8($0)
8c09000c  // 0x24 lw    $9, 12($0)
24000007  // 0x28 addiu $0, $0, 7
00025025  // 0x2c or    $10, $0, $2
11020001  // 0x30 beq   $8, $2, +1   taken
240b0001  // 0x34 addiu $11, $0, 1   skipped
15020001  // 0x38 bne   $8, $2, +1   not taken
14220001  // 0x3c bne   $1, $2, +1   taken
240b0002  // 0x40 addiu $11, $0, 2   skipped
10220001  // 0x44 beq   $1, $2, +1   not taken
0c000014  // 0x48 jal   0x50
08000013  // 0x4c j     0x4c
03e00008  // 0x50 jr    $31

// ==== sources.f ====
mips_isa_pkg.sv
cpu_ctrl_pkg.sv
stage_if.sv
mips_regfile.sv
mips_decode.sv
mips_execute.sv
mips_result.sv
mips_cpu.sv
tb_retire_checker.sv
tb_mips_cpu.sv

// ==== Bender.yml ====
package:
  name: mips_cpu

sources:
  - mips_isa_pkg.sv
  - cpu_ctrl_pkg.sv
  - stage_if.sv
  - mips_regfile.sv
  - mips_decode.sv
  - mips_execute.sv
  - mips_result.sv
  - mips_cpu.sv
  - target: test
    files:
      - tb_retire_checker.sv
      - tb_mips_cpu.sv
